// ==== sim.f ====
pb_pkg.sv
page_allocator.sv
page_store.sv
pkt_descriptor.sv
wb_read_port.sv
pkt_buffer_top.sv
pkt_buffer_assert.sv
tb_pkt_buffer.sv

// ==== run.sh ====
#!/bin/sh
# compile with verilator, run, and look for the pass line in the log.
verilator --binary --timing --assert --top-module tb_pkt_buffer -f sim.f \
    && { ./obj_dir/Vtb_pkt_buffer > sim.log 2>&1 || true; } \
    && grep -qx "NO ERRORS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb_pkt_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_pkt_buffer import pb_pkg::*; ();

    localparam logic [4:0] BANK = 5'd5;
    // reset plus the self-fill of 2047 pages.
    localparam int INIT_CLOCKS = 10 + 2047;
    localparam int TIMEOUT_CLOCKS = INIT_CLOCKS + 4000;

    logic                 clk;
    logic                 rst_n;
    logic [4:0]           time_stamp;
    logic                 xfer_data_vld;
    pb_word_u             xfer_data;
    logic                 end_of_packet;
    logic                 concatenate_enable;
    logic [PAGE_BITS-1:0] concatenate_head;
    logic [PAGE_BITS-1:0] concatenate_tail;
    logic [3:0]           dest_port;
    logic [2:0]           prior;
    logic [ADDR_BITS-1:0] head_addr;
    logic [ADDR_BITS-1:0] tail_addr;
    logic                 join_request;
    logic [5:0]           join_time_stamp;
    logic                 init_done;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [15:0]          wb_adr;
    logic [15:0]          wb_dat_o;
    logic                 wb_ack;

    // reference model of the bank contents.
    logic [15:0]          exp_data [WORDS];
    logic [7:0]           exp_par [PAGES];
    logic [PAGE_BITS-1:0] exp_jt [PAGES];
    int                   page_words [PAGES];
    // pages are handed out in rising order from page 0.
    logic [PAGE_BITS-1:0] next_page;
    logic [31:0]          rng;
    int                   cycle;
    int                   errors;

    pkt_buffer_top #(
        .BANK_IDX (BANK)
    ) pkt_buffer_top_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .time_stamp         (time_stamp),
        .xfer_data_vld      (xfer_data_vld),
        .xfer_data          (xfer_data),
        .end_of_packet      (end_of_packet),
        .concatenate_enable (concatenate_enable),
        .concatenate_head   (concatenate_head),
        .concatenate_tail   (concatenate_tail),
        .dest_port          (dest_port),
        .prior              (prior),
        .head_addr          (head_addr),
        .tail_addr          (tail_addr),
        .join_request       (join_request),
        .join_time_stamp    (join_time_stamp),
        .init_done          (init_done),
        .wb_cyc             (wb_cyc),
        .wb_stb             (wb_stb),
        .wb_we              (wb_we),
        .wb_adr             (wb_adr),
        .wb_dat_o           (wb_dat_o),
        .wb_ack             (wb_ack)
    );

    always #5 clk = ~clk;

    // free-running stamp, one count per clock.
    always @(posedge clk) begin
        time_stamp <= time_stamp + 5'd1;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CLOCKS) begin
            $display("timeout, the tests did not finish within %0d clocks", TIMEOUT_CLOCKS);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_run(input string line);
        errors = errors + 1;
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input pb_word_u got, input pb_word_u exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got.raw, exp.raw));
        end
    endtask

    task automatic check_parity(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_page(input logic [PAGE_BITS-1:0] got, input logic [PAGE_BITS-1:0] exp,
                              input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_stamp(input logic [5:0] got, input logic [5:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: join_time_stamp got %0d expected %0d",
                               $time, got, exp));
        end
    endtask

    task automatic check_descriptor(input logic [3:0] got_dest, input logic [2:0] got_prior,
                                    input logic [15:0] got_head, input logic [15:0] got_tail,
                                    input logic [3:0] exp_dest, input logic [2:0] exp_prior,
                                    input logic [15:0] exp_head, input logic [15:0] exp_tail);
        if (got_dest !== exp_dest || got_prior !== exp_prior ||
            got_head !== exp_head || got_tail !== exp_tail) begin
            stop_run($sformatf("[FAIL] %0t: descriptor got %h/%h/%h/%h expected %h/%h/%h/%h",
                               $time, got_dest, got_prior, got_head, got_tail,
                               exp_dest, exp_prior, exp_head, exp_tail));
        end
    endtask

    // one word into the model, parity is the xor of both bytes of every word.
    task automatic model_word(input logic [PAGE_BITS-1:0] page, input logic [2:0] b,
                              input logic [15:0] data);
        if (b == 3'd0) begin
            exp_par[page] = 8'h00;
        end
        exp_data[{page, b}] = data;
        exp_par[page] = exp_par[page] ^ data[15:8] ^ data[7:0];
        // every ended page links to the next free page.
        exp_jt[page] = page + 11'd1;
        page_words[page] = int'(b) + 1;
    endtask

    task automatic wb_read(input logic [15:0] adr, output logic [15:0] data);
        int waited;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        waited = 0;
        @(negedge clk);
        while (!wb_ack && waited < 8) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (!wb_ack) begin
            stop_run($sformatf("no Wishbone ack came for address %h", adr));
        end else if (waited != 1) begin
            stop_run($sformatf("Wishbone ack for address %h was not one clock late", adr));
        end
        data = wb_dat_o;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // sends one packet and follows the descriptor and stamp clock by clock.
    task automatic send_packet(input logic [5:0] pc, input logic [2:0] ll, input logic [2:0] pri,
                               input logic [3:0] dest, input int idle);
        pb_word_u             head_word;
        pb_word_u             word;
        int                   len;
        int                   i;
        logic [PAGE_BITS-1:0] head;
        logic [4:0]           ts_hdr;
        logic [15:0]          exp_head;
        logic [15:0]          exp_tail;
        head_word.hdr.page_count = pc;
        head_word.hdr.last_len   = ll;
        head_word.hdr.prior      = pri;
        head_word.hdr.dest_port  = dest;
        len = (int'(pc) - 1) * 8 + ((ll == 3'd0) ? 8 : int'(ll));
        head = next_page;
        exp_head = {BANK, head};
        exp_tail = {BANK, head + 11'(pc) - 11'd1};
        ts_hdr = 5'd0;
        for (i = 0; i < len + idle; i++) begin
            @(posedge clk);
            if (i < len) begin
                if (i == 0) begin
                    word = head_word;
                end else begin
                    rng = xorshift32(rng);
                    word.raw = rng[15:0];
                end
                model_word(head + 11'(i / 8), 3'(i % 8), word.raw);
                xfer_data_vld <= 1'b1;
                xfer_data     <= word;
                end_of_packet <= (i == len - 1);
            end else begin
                xfer_data_vld <= 1'b0;
                end_of_packet <= 1'b0;
            end
            @(negedge clk);
            // stamp seen by the dut together with the header.
            if (i == 0) begin
                ts_hdr = time_stamp;
            end
            check_flag(join_request, i == 2, "join_request");
            if (i >= 2) begin
                check_descriptor(dest_port, prior, head_addr, tail_addr,
                                 dest, pri, exp_head, exp_tail);
            end
            if (i >= 1) begin
                check_stamp(join_time_stamp, (i <= 32) ? {1'b0, ts_hdr + 5'd1} : 6'd32);
            end
        end
        next_page = head + 11'(pc);
    endtask

    // reads back data, parity and jump entries of a run of pages.
    task automatic verify_pages(input logic [PAGE_BITS-1:0] head, input logic [5:0] pc);
        logic [15:0]          d;
        logic [PAGE_BITS-1:0] p;
        int                   k;
        int                   b;
        for (k = 0; k < int'(pc); k++) begin
            p = head + 11'(k);
            for (b = 0; b < page_words[p]; b++) begin
                wb_read({DATA, p, 3'(b)}, d);
                check_word(d, exp_data[{p, 3'(b)}], $sformatf("page %0d word %0d", p, b));
            end
            wb_read({PARITY, 3'b000, p}, d);
            check_parity(d[7:0], exp_par[p], $sformatf("parity of page %0d", p));
            check_parity(d[15:8], 8'h00, "parity upper byte");
            wb_read({JUMP, 3'b000, p}, d);
            check_page(d[10:0], exp_jt[p], $sformatf("jump entry of page %0d", p));
        end
    endtask

    task automatic run_three_page_packet();
        send_packet(6'd3, 3'd0, 3'd6, 4'd9, 3);
        verify_pages(11'd0, 6'd3);
    endtask

    task automatic run_short_last_page();
        logic [PAGE_BITS-1:0] head;
        head = next_page;
        send_packet(6'd2, 3'd3, 3'd1, 4'd3, 3);
        verify_pages(head, 6'd2);
    endtask

    // concatenation on an idle stream, so no page end shares the clock.
    task automatic run_concatenation(input logic [PAGE_BITS-1:0] head,
                                     input logic [PAGE_BITS-1:0] tail);
        logic [15:0] d;
        @(posedge clk);
        concatenate_enable <= 1'b1;
        concatenate_head   <= head;
        concatenate_tail   <= tail;
        @(posedge clk);
        concatenate_enable <= 1'b0;
        exp_jt[head] = tail;
        wb_read({JUMP, 3'b000, head}, d);
        check_page(d[10:0], exp_jt[head], "jump entry after concatenation");
    endtask

    task automatic run_stamp_expiry();
        logic [PAGE_BITS-1:0] head;
        head = next_page;
        // long idle tail lets the stamp run out.
        send_packet(6'd1, 3'd5, 3'd2, 4'd12, 40);
        verify_pages(head, 6'd1);
    endtask

    task automatic run_random_packets();
        logic [PAGE_BITS-1:0] head;
        logic [5:0]           pc;
        int                   n;
        for (n = 0; n < 20; n++) begin
            rng = xorshift32(rng);
            pc = 6'(32'd1 + rng % 32'd3);
            head = next_page;
            send_packet(pc, rng[10:8], rng[13:11], rng[17:14], 3);
            verify_pages(head, pc);
        end
    endtask

    initial begin
        int p;
        clk                = 1'b0;
        rst_n              = 1'b0;
        time_stamp         = 5'd0;
        xfer_data_vld      = 1'b0;
        xfer_data          = '0;
        end_of_packet      = 1'b0;
        concatenate_enable = 1'b0;
        concatenate_head   = '0;
        concatenate_tail   = '0;
        wb_cyc             = 1'b0;
        wb_stb             = 1'b0;
        wb_we              = 1'b0;
        wb_adr             = '0;
        rng                = 32'd78603;
        next_page          = '0;
        cycle              = 0;
        errors             = 0;
        for (p = 0; p < PAGES; p++) begin
            page_words[p] = 0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        while (!init_done) begin
            @(negedge clk);
        end
        run_three_page_packet();
        run_short_last_page();
        run_concatenation(11'd1, 11'd1234);
        run_stamp_expiry();
        run_random_packets();
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pkt_buffer_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module pkt_buffer_assert (
    input logic clk,
    input logic rst_n,
    input logic concatenate_enable,
    input logic page_end,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic join_request
);

    // the jump table has one write port, a page end owns it.
    a_no_concat_on_page_end: assert property (
        @(posedge clk) disable iff (!rst_n) !(concatenate_enable && page_end)
    ) else $error("concatenation on a page end clock");

    // ack only answers a live request.
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) wb_ack |-> (wb_cyc && wb_stb)
    ) else $error("wishbone ack outside cyc and stb");

    a_join_single: assert property (
        @(posedge clk) disable iff (!rst_n) join_request |=> !join_request
    ) else $error("join_request high on two clocks in a row");

endmodule

bind pkt_buffer_top pkt_buffer_assert pkt_buffer_assert_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .concatenate_enable (concatenate_enable),
    .page_end           (page_end),
    .wb_cyc             (wb_cyc),
    .wb_stb             (wb_stb),
    .wb_ack             (wb_ack),
    .join_request       (join_request)
);

`default_nettype wire

// ==== pkt_buffer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pkt_buffer_top import pb_pkg::*; #(
    parameter logic [BANK_BITS-1:0] BANK_IDX = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [4:0]           time_stamp,
    // input stream.
    input  logic                 xfer_data_vld,
    input  pb_word_u             xfer_data,
    input  logic                 end_of_packet,
    // jump-table concatenation.
    input  logic                 concatenate_enable,
    input  logic [PAGE_BITS-1:0] concatenate_head,
    input  logic [PAGE_BITS-1:0] concatenate_tail,
    // enqueue descriptor.
    output logic [3:0]           dest_port,
    output logic [2:0]           prior,
    output logic [ADDR_BITS-1:0] head_addr,
    output logic [ADDR_BITS-1:0] tail_addr,
    output logic                 join_request,
    output logic [5:0]           join_time_stamp,
    output logic                 init_done,
    // wishbone read port.
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [15:0]          wb_adr,
    output logic [15:0]          wb_dat_o,
    output logic                 wb_ack
);

    // page framing from the allocator.
    logic [PAGE_BITS-1:0]            cur_page;
    logic [PAGE_BITS-1:0]            tail_page;
    logic [BATCH_BITS-1:0]           batch;
    logic                            page_end;
    logic                            pkt_start;
    // read side of the memories.
    logic [PAGE_BITS-1:0]            jt_rd_addr;
    logic [PAGE_BITS-1:0]            jt_rd_data;
    logic [PAGE_BITS+BATCH_BITS-1:0] rd_data_addr;
    logic [DATA_BITS-1:0]            rd_data;
    logic [PAGE_BITS-1:0]            rd_par_addr;
    logic [7:0]                      rd_par;

    page_allocator page_allocator_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .xfer_data_vld      (xfer_data_vld),
        .end_of_packet      (end_of_packet),
        .xfer_data          (xfer_data),
        .concatenate_enable (concatenate_enable),
        .concatenate_head   (concatenate_head),
        .concatenate_tail   (concatenate_tail),
        .jt_rd_addr         (jt_rd_addr),
        .jt_rd_data         (jt_rd_data),
        .cur_page           (cur_page),
        .tail_page          (tail_page),
        .batch              (batch),
        .page_end           (page_end),
        .pkt_start          (pkt_start),
        .init_done          (init_done)
    );

    page_store page_store_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .xfer_data_vld (xfer_data_vld),
        .xfer_data     (xfer_data),
        .cur_page      (cur_page),
        .batch         (batch),
        .page_end      (page_end),
        .rd_data_addr  (rd_data_addr),
        .rd_data       (rd_data),
        .rd_par_addr   (rd_par_addr),
        .rd_par        (rd_par)
    );

    pkt_descriptor #(
        .BANK_IDX (BANK_IDX)
    ) pkt_descriptor_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .xfer_data       (xfer_data),
        .pkt_start       (pkt_start),
        .cur_page        (cur_page),
        .tail_page       (tail_page),
        .time_stamp      (time_stamp),
        .dest_port       (dest_port),
        .prior           (prior),
        .head_addr       (head_addr),
        .tail_addr       (tail_addr),
        .join_request    (join_request),
        .join_time_stamp (join_time_stamp)
    );

    wb_read_port wb_read_port_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_o     (wb_dat_o),
        .wb_ack       (wb_ack),
        .rd_data_addr (rd_data_addr),
        .rd_par_addr  (rd_par_addr),
        .jt_rd_addr   (jt_rd_addr),
        .rd_data      (rd_data),
        .rd_par       (rd_par),
        .jt_rd_data   (jt_rd_data)
    );

endmodule

`default_nettype wire

// ==== wb_read_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_read_port import pb_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [15:0]                     wb_adr,
    output logic [15:0]                     wb_dat_o,
    output logic                            wb_ack,
    output logic [PAGE_BITS+BATCH_BITS-1:0] rd_data_addr,
    output logic [PAGE_BITS-1:0]            rd_par_addr,
    output logic [PAGE_BITS-1:0]            jt_rd_addr,
    input  logic [DATA_BITS-1:0]            rd_data,
    input  logic [7:0]                      rd_par,
    input  logic [PAGE_BITS-1:0]            jt_rd_data
);

    wb_region_e region;
    wb_region_e region_q;
    logic       we_q;
    // request seen, not yet answered.
    logic       req;

    assign region = wb_region_e'(wb_adr[15:14]);
    assign req    = wb_cyc && wb_stb && !wb_ack;

    // the rams register the read on the request clock.
    assign rd_data_addr = wb_adr[PAGE_BITS+BATCH_BITS-1:0];
    assign rd_par_addr  = wb_adr[PAGE_BITS-1:0];
    assign jt_rd_addr   = wb_adr[PAGE_BITS-1:0];

    // single clock ack, one clock after the request.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // remember where the data comes from.
    always_ff @(posedge clk) begin
        if (req) begin
            region_q <= region;
            we_q     <= wb_we;
        end
    end

    // return mux, unused upper bits are zero.
    // a write is acked with zero data.
    always_comb begin
        wb_dat_o = '0;
        if (!we_q) begin
            case (region_q)
                DATA:    wb_dat_o = rd_data;
                PARITY:  wb_dat_o = {8'h00, rd_par};
                JUMP:    wb_dat_o = {{(16 - PAGE_BITS){1'b0}}, jt_rd_data};
                default: wb_dat_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== pkt_descriptor.sv ====
`timescale 1ns/1ns
`default_nettype none

module pkt_descriptor import pb_pkg::*; #(
    parameter logic [BANK_BITS-1:0] BANK_IDX = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pb_word_u             xfer_data,
    input  logic                 pkt_start,
    input  logic [PAGE_BITS-1:0] cur_page,
    input  logic [PAGE_BITS-1:0] tail_page,
    input  logic [4:0]           time_stamp,
    output logic [3:0]           dest_port,
    output logic [2:0]           prior,
    output logic [ADDR_BITS-1:0] head_addr,
    output logic [ADDR_BITS-1:0] tail_addr,
    output logic                 join_request,
    output logic [5:0]           join_time_stamp
);

    // header fields held until the tail page is known.
    logic [3:0]           dest_q;
    logic [2:0]           prior_q;
    logic [PAGE_BITS-1:0] head_q;
    // one clock after the header.
    logic                 pend;
    logic [4:0]           ts_next;

    assign ts_next = time_stamp + 5'd1;

    // first stage, decode the header word.
    always_ff @(posedge clk) begin
        if (pkt_start) begin
            dest_q  <= xfer_data.hdr.dest_port;
            prior_q <= xfer_data.hdr.prior;
            head_q  <= cur_page;
        end
    end

    // second stage, the tail page from the allocator is now valid.
    // a header in the same clock only refills the first stage.
    always_ff @(posedge clk) begin
        if (pend) begin
            dest_port <= dest_q;
            prior     <= prior_q;
            head_addr <= {BANK_IDX, head_q};
            tail_addr <= {BANK_IDX, tail_page};
        end
    end

    // join request pulses two clocks after the header.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend         <= 1'b0;
            join_request <= 1'b0;
        end else begin
            pend         <= pkt_start;
            join_request <= pend;
        end
    end

    // stamp is taken at the header.
    // it falls back to 32 once the counter comes round to it again.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            join_time_stamp <= 6'd32;
        end else if (pkt_start) begin
            join_time_stamp <= {1'b0, ts_next};
        end else if ({1'b0, ts_next} == join_time_stamp) begin
            join_time_stamp <= 6'd32;
        end
    end

endmodule

`default_nettype wire

// ==== page_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module page_store import pb_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            xfer_data_vld,
    input  pb_word_u                        xfer_data,
    input  logic [PAGE_BITS-1:0]            cur_page,
    input  logic [BATCH_BITS-1:0]           batch,
    input  logic                            page_end,
    input  logic [PAGE_BITS+BATCH_BITS-1:0] rd_data_addr,
    output logic [DATA_BITS-1:0]            rd_data,
    input  logic [PAGE_BITS-1:0]            rd_par_addr,
    output logic [7:0]                      rd_par
);

    // packet data, addressed by page and word.
    logic [DATA_BITS-1:0]            data_mem [WORDS];
    // one parity byte per page.
    logic [7:0]                      par_mem [PAGES];
    // copy of the words of the current page.
    logic [DATA_BITS-1:0]            page_buf [8];
    logic [PAGE_BITS+BATCH_BITS-1:0] wr_addr;
    logic [DATA_BITS-1:0]            page_fold;
    logic [7:0]                      par_byte;

    assign wr_addr = {cur_page, batch};

    // word lands in the data ram on the clock it is accepted.
    always_ff @(posedge clk) begin
        if (xfer_data_vld) begin
            data_mem[wr_addr] <= xfer_data.raw;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= data_mem[rd_data_addr];
    end

    // page buffer.
    // entries 1 to 7 are cleared with word 0, so unwritten words stay zero.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                page_buf[i] <= '0;
            end
        end else if (xfer_data_vld) begin
            if (batch == '0) begin
                for (int i = 1; i < 8; i++) begin
                    page_buf[i] <= '0;
                end
            end
            page_buf[batch] <= xfer_data.raw;
        end
    end

    // fold the page with the word that ends it.
    // a one-word page still holds the old page in the buffer, so it is skipped.
    always_comb begin
        page_fold = xfer_data.raw;
        if (batch != '0) begin
            for (int i = 0; i < 8; i++) begin
                page_fold = page_fold ^ page_buf[i];
            end
        end
    end

    // high byte against low byte.
    assign par_byte = page_fold[15:8] ^ page_fold[7:0];

    always_ff @(posedge clk) begin
        if (page_end) begin
            par_mem[cur_page] <= par_byte;
        end
    end

    always_ff @(posedge clk) begin
        rd_par <= par_mem[rd_par_addr];
    end

endmodule

`default_nettype wire

// ==== page_allocator.sv ====
`timescale 1ns/1ns
`default_nettype none

module page_allocator import pb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  xfer_data_vld,
    input  logic                  end_of_packet,
    input  pb_word_u              xfer_data,
    input  logic                  concatenate_enable,
    input  logic [PAGE_BITS-1:0]  concatenate_head,
    input  logic [PAGE_BITS-1:0]  concatenate_tail,
    input  logic [PAGE_BITS-1:0]  jt_rd_addr,
    output logic [PAGE_BITS-1:0]  jt_rd_data,
    output logic [PAGE_BITS-1:0]  cur_page,
    output logic [PAGE_BITS-1:0]  tail_page,
    output logic [BATCH_BITS-1:0] batch,
    output logic                  page_end,
    output logic                  pkt_start,
    output logic                  init_done
);

    // free-page queue storage.
    logic [PAGE_BITS-1:0] fq_mem [PAGES];
    logic [PAGE_BITS-1:0] fq_wr_ptr;
    logic [PAGE_BITS-1:0] fq_rd_ptr;
    logic [PAGE_BITS-1:0] fill_page;
    logic                 fill_en;
    logic [PAGE_BITS-1:0] fq_rd_addr;
    logic [PAGE_BITS-1:0] fq_head;
    logic [PAGE_BITS-1:0] tail_rd_addr;
    // high while a packet is in flight.
    logic                 in_pkt;
    // successor page of every page.
    logic [PAGE_BITS-1:0] jt_mem [PAGES];

    // first word after reset or after an end of packet is the header.
    assign pkt_start = xfer_data_vld && !in_pkt;
    // eighth word or the packet's last word closes the page.
    assign page_end = xfer_data_vld && (batch == '1 || end_of_packet);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_pkt <= 1'b0;
        end else if (xfer_data_vld) begin
            in_pkt <= !end_of_packet;
        end
    end

    // word index inside the current page.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            batch <= '0;
        end else if (page_end) begin
            batch <= '0;
        end else if (xfer_data_vld) begin
            batch <= batch + 1'b1;
        end
    end

    // self-fill with pages 1 to 2047, page 0 is already current.
    assign fill_en = rst_n && !init_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_page <= PAGE_BITS'(1);
            fq_wr_ptr <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            fill_page <= fill_page + 1'b1;
            fq_wr_ptr <= fq_wr_ptr + 1'b1;
            // last page written on this clock.
            if (fill_page == '1) begin
                init_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            fq_mem[fq_wr_ptr] <= fill_page;
        end
    end

    // one page leaves the queue at every page end.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fq_rd_ptr <= '0;
        end else if (page_end) begin
            fq_rd_ptr <= fq_rd_ptr + 1'b1;
        end
    end

    // head of queue is read ahead so back to back page ends see the right page.
    assign fq_rd_addr = page_end ? fq_rd_ptr + 1'b1 : fq_rd_ptr;

    always_ff @(posedge clk) begin
        fq_head <= fq_mem[fq_rd_addr];
    end

    // the next free page becomes current on the page end clock.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_page <= '0;
        end else if (page_end) begin
            cur_page <= fq_head;
        end
    end

    // pages after the head come from the queue in order.
    // the last one sits page_count minus 2 entries past the read pointer.
    assign tail_rd_addr = fq_rd_ptr + PAGE_BITS'(xfer_data.hdr.page_count) - PAGE_BITS'(2);

    always_ff @(posedge clk) begin
        if (pkt_start) begin
            if (xfer_data.hdr.page_count > 6'd1) begin
                tail_page <= fq_mem[tail_rd_addr];
            end else begin
                tail_page <= cur_page;
            end
        end
    end

    // concatenation takes the write port, page ends never overlap it.
    always_ff @(posedge clk) begin
        if (concatenate_enable) begin
            jt_mem[concatenate_head] <= concatenate_tail;
        end else if (page_end) begin
            // last page of a packet also links to the next free page.
            jt_mem[cur_page] <= fq_head;
        end
    end

    always_ff @(posedge clk) begin
        jt_rd_data <= jt_mem[jt_rd_addr];
    end

endmodule

`default_nettype wire

// ==== pb_pkg.sv ====
`default_nettype none

package pb_pkg;

    // page number width, 2048 pages per bank.
    localparam int PAGE_BITS = 11;
    // word index inside one page of eight words.
    localparam int BATCH_BITS = 3;
    // packet address is the bank index on top of the page.
    localparam int ADDR_BITS = 16;
    localparam int BANK_BITS = ADDR_BITS - PAGE_BITS;
    // stream word width.
    localparam int DATA_BITS = 16;
    // memory depths.
    localparam int PAGES = 1 << PAGE_BITS;
    localparam int WORDS = 1 << (PAGE_BITS + BATCH_BITS);

    // header fields, top bit first.
    typedef struct packed {
        // pages in the packet, never 0.
        logic [5:0] page_count;
        // words in the last page, 0 stands for 8.
        logic [2:0] last_len;
        logic [2:0] prior;
        logic [3:0] dest_port;
    } pb_header_t;

    // one stream word seen either as data or as a header.
    typedef union packed {
        logic [DATA_BITS-1:0] raw;
        pb_header_t           hdr;
    } pb_word_u;

    // wishbone address region in adr[15:14].
    typedef enum logic [1:0] {
        DATA   = 2'd0,
        PARITY = 2'd1,
        JUMP   = 2'd2
    } wb_region_e;

endpackage

`default_nettype wire
